//--- design/cspi_pkg.sv
// shared types and constants for the control-SPI master; timing is fixed at elaboration, no runtime programming
package cspi_pkg;

	// ------------------------------------------------------------------------
	// sizes
	// ------------------------------------------------------------------------
	localparam int ADDR_W        = 7;
	localparam int DATA_W        = 8;
	localparam int FIFO_DEPTH    = 4;
	// depth must stay a power of two so the pointers wrap on their own
	localparam int FIFO_PTR_W    = $clog2(FIFO_DEPTH);
	localparam int FIFO_CNT_W    = FIFO_PTR_W + 1;

	// ------------------------------------------------------------------------
	// bus timing in system clocks
	// ------------------------------------------------------------------------
	localparam int PHASE_CYCLES  = 10;
	localparam int GAP_CYCLES    = 65;
	localparam int BITS_PER_BYTE = 8;
	localparam int PHASE_CNT_W   = $clog2(PHASE_CYCLES);
	localparam int GAP_CNT_W     = $clog2(GAP_CYCLES);
	localparam int BIT_CNT_W     = $clog2(BITS_PER_BYTE);

	// command opcode, the value doubles as bit 7 of the header byte
	typedef enum logic [0:0] {
		OP_WRITE = 1'b0,
		OP_READ  = 1'b1
	} cmd_op_e;

	// byte engine states
	typedef enum logic [2:0] {
		PHY_IDLE  = 3'h0,
		PHY_BIT   = 3'h1,
		PHY_LOW   = 3'h2,
		PHY_HIGH  = 3'h3,
		PHY_CHECK = 3'h4,
		PHY_GAP   = 3'h5,
		PHY_DONE  = 3'h7
	} phy_state_e;

	// transfer sequencer states
	typedef enum logic [2:0] {
		CTL_IDLE      = 3'h0,
		CTL_HEAD      = 3'h1,
		CTL_HEAD_WAIT = 3'h2,
		CTL_DATA      = 3'h3,
		CTL_DATA_WAIT = 3'h4,
		CTL_RSP       = 3'h5
	} ctl_state_e;

endpackage

//--- design/cspi_cmd_fifo.sv
// command buffer of FIFO_DEPTH entries; push_ready is registered, so it is low in reset and one clock after
module cspi_cmd_fifo import cspi_pkg::*; (
	input  logic              clk_sys,
	input  logic              rst_n,
	input  logic              push_valid,
	input  cmd_op_e           push_op,
	input  logic [ADDR_W-1:0] push_addr,
	input  logic [DATA_W-1:0] push_data,
	output logic              push_ready,
	output logic              pop_valid,
	output cmd_op_e           pop_op,
	output logic [ADDR_W-1:0] pop_addr,
	output logic [DATA_W-1:0] pop_data,
	input  logic              pop_ready
);

	// storage, no reset needed
	cmd_op_e             op_mem   [FIFO_DEPTH];
	logic [ADDR_W-1:0]   addr_mem [FIFO_DEPTH];
	logic [DATA_W-1:0]   data_mem [FIFO_DEPTH];

	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [FIFO_CNT_W-1:0] count;
	logic [FIFO_CNT_W-1:0] count_next;
	logic                  push_fire;
	logic                  pop_fire;

	assign push_fire = push_valid & push_ready;
	assign pop_fire  = pop_valid & pop_ready;

	always_comb begin
		case ({push_fire, pop_fire})
			2'b10:   count_next = count + 1'b1;
			2'b01:   count_next = count - 1'b1;
			default: count_next = count;
		endcase
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			push_ready <= 1'b0;
		end else begin
			if (push_fire)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop_fire)
				rd_ptr <= rd_ptr + 1'b1;
			count      <= count_next;
			// space freed by a pop shows up on the next clock
			push_ready <= (count_next != FIFO_CNT_W'(FIFO_DEPTH));
		end
	end

	always_ff @(posedge clk_sys) begin
		if (push_fire) begin
			op_mem[wr_ptr]   <= push_op;
			addr_mem[wr_ptr] <= push_addr;
			data_mem[wr_ptr] <= push_data;
		end
	end

	// head entry read straight out of the array
	assign pop_valid = (count != '0);
	assign pop_op    = op_mem[rd_ptr];
	assign pop_addr  = addr_mem[rd_ptr];
	assign pop_data  = data_mem[rd_ptr];

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------
	a_count_bound: assert property (@(posedge clk_sys) disable iff (!rst_n)
		count <= FIFO_CNT_W'(FIFO_DEPTH));

	a_pop_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
		pop_valid && !pop_ready |=> pop_valid && $stable(pop_op) &&
			$stable(pop_addr) && $stable(pop_data));

endmodule

//--- design/cspi_byte_phy.sv
// one-byte SPI frame, mode 3 style (sck idles high), MSB first; fire is only honoured in PHY_IDLE
module cspi_byte_phy import cspi_pkg::*; (
	input  logic              clk_sys,
	input  logic              rst_n,
	input  logic              fire,
	input  logic [DATA_W-1:0] tx_data,
	output logic              done,
	output logic [DATA_W-1:0] rx_data,
	output logic              cspi_csn,
	output logic              cspi_sck,
	output logic              cspi_mosi,
	input  logic              cspi_miso
);

	phy_state_e             state;
	logic [PHASE_CNT_W-1:0] cnt_phase;
	logic [BIT_CNT_W-1:0]   cnt_bits;
	logic [GAP_CNT_W-1:0]   cnt_gap;
	logic [DATA_W-1:0]      tx_sr;
	logic                   phase_last;
	logic                   byte_last;
	logic                   gap_last;

	// ------------------------------------------------------------------------
	// frame FSM
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state <= PHY_IDLE;
		end else begin
			case (state)
				PHY_IDLE:  state <= fire ? PHY_BIT : PHY_IDLE;
				PHY_BIT:   state <= PHY_LOW;
				PHY_LOW:   state <= phase_last ? PHY_HIGH : PHY_LOW;
				PHY_HIGH:  state <= phase_last ? PHY_CHECK : PHY_HIGH;
				PHY_CHECK: state <= byte_last ? PHY_GAP : PHY_BIT;
				PHY_GAP:   state <= gap_last ? PHY_DONE : PHY_GAP;
				PHY_DONE:  state <= PHY_IDLE;
				default:   state <= PHY_IDLE;
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// counters
	// ------------------------------------------------------------------------
	// shared by the low and high phase, restarts at each phase boundary
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			cnt_phase <= '0;
		else if ((state == PHY_LOW || state == PHY_HIGH) && !phase_last)
			cnt_phase <= cnt_phase + 1'b1;
		else
			cnt_phase <= '0;
	end
	assign phase_last = (cnt_phase == PHASE_CNT_W'(PHASE_CYCLES - 1));

	// wraps back to zero after the last bit
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			cnt_bits <= '0;
		else if (state == PHY_CHECK)
			cnt_bits <= cnt_bits + 1'b1;
		else if (state == PHY_DONE)
			cnt_bits <= '0;
	end
	assign byte_last = (cnt_bits == BIT_CNT_W'(BITS_PER_BYTE - 1));

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			cnt_gap <= '0;
		else if (state == PHY_GAP)
			cnt_gap <= cnt_gap + 1'b1;
		else
			cnt_gap <= '0;
	end
	assign gap_last = (cnt_gap == GAP_CNT_W'(GAP_CYCLES - 1));

	// ------------------------------------------------------------------------
	// data path
	// ------------------------------------------------------------------------
	// shifted empty by the end of the frame, so mosi rests low
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			tx_sr <= '0;
		else if (fire)
			tx_sr <= tx_data;
		else if (state == PHY_CHECK)
			tx_sr <= {tx_sr[DATA_W-2:0], 1'b0};
	end

	// sample on the last low cycle, just before sck rises
	always_ff @(posedge clk_sys) begin
		if (state == PHY_LOW && phase_last)
			rx_data <= {rx_data[DATA_W-2:0], cspi_miso};
	end

	assign done      = (state == PHY_DONE);
	assign cspi_csn  = (state == PHY_IDLE) || (state == PHY_GAP) || (state == PHY_DONE);
	assign cspi_sck  = (state != PHY_BIT) && (state != PHY_LOW);
	assign cspi_mosi = tx_sr[DATA_W-1];

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------
	a_fire_idle: assert property (@(posedge clk_sys) disable iff (!rst_n)
		fire |-> state == PHY_IDLE);

endmodule

//--- design/cspi_xfer_ctrl.sv
// one command at a time, header frame then data frame; a read parks in CTL_RSP until accepted
module cspi_xfer_ctrl import cspi_pkg::*; (
	input  logic              clk_sys,
	input  logic              rst_n,
	input  logic              pop_valid,
	input  cmd_op_e           pop_op,
	input  logic [ADDR_W-1:0] pop_addr,
	input  logic [DATA_W-1:0] pop_data,
	output logic              pop_ready,
	output logic              fire,
	output logic [DATA_W-1:0] tx_data,
	input  logic              done,
	input  logic [DATA_W-1:0] rx_data,
	output logic              rsp_valid,
	output logic [DATA_W-1:0] rsp_data,
	input  logic              rsp_ready
);

	ctl_state_e        state;
	cmd_op_e           op_q;
	logic [ADDR_W-1:0] addr_q;
	logic [DATA_W-1:0] wdata_q;
	logic [DATA_W-1:0] rsp_q;
	logic [DATA_W-1:0] head_byte;
	logic [DATA_W-1:0] data_byte;
	logic              pop_fire;
	logic              phy_busy;

	assign pop_fire = pop_valid & pop_ready;

	// ------------------------------------------------------------------------
	// sequencer
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state <= CTL_IDLE;
		end else begin
			case (state)
				CTL_IDLE: begin
					if (pop_fire)
						state <= CTL_HEAD;
				end
				CTL_HEAD: begin
					state <= CTL_HEAD_WAIT;
				end
				CTL_HEAD_WAIT: begin
					if (done)
						state <= CTL_DATA;
				end
				CTL_DATA: begin
					state <= CTL_DATA_WAIT;
				end
				CTL_DATA_WAIT: begin
					// writes finish here, no response
					if (done)
						state <= (op_q == OP_READ) ? CTL_RSP : CTL_IDLE;
				end
				CTL_RSP: begin
					if (rsp_ready)
						state <= CTL_IDLE;
				end
				default: begin
					state <= CTL_IDLE;
				end
			endcase
		end
	end

	// command fields latched at pop
	always_ff @(posedge clk_sys) begin
		if (pop_fire) begin
			op_q    <= pop_op;
			addr_q  <= pop_addr;
			wdata_q <= pop_data;
		end
	end

	// byte captured during the data frame of a read
	always_ff @(posedge clk_sys) begin
		if (state == CTL_DATA_WAIT && done)
			rsp_q <= rx_data;
	end

	// ------------------------------------------------------------------------
	// outputs
	// ------------------------------------------------------------------------
	assign head_byte = {(op_q == OP_READ), addr_q};
	assign data_byte = (op_q == OP_READ) ? '0 : wdata_q;

	assign pop_ready = (state == CTL_IDLE);
	assign fire      = (state == CTL_HEAD) || (state == CTL_DATA);
	assign tx_data   = (state == CTL_HEAD) ? head_byte : data_byte;
	assign rsp_valid = (state == CTL_RSP);
	assign rsp_data  = rsp_q;

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------
	// tracks an open frame on the PHY
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			phy_busy <= 1'b0;
		else if (fire)
			phy_busy <= 1'b1;
		else if (done)
			phy_busy <= 1'b0;
	end

	a_no_refire: assert property (@(posedge clk_sys) disable iff (!rst_n)
		phy_busy |-> !fire);

	a_rsp_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data));

endmodule

//--- design/cspi_master_top.sv
// control-SPI master, single chip select, fixed bus rate; one command in flight on the bus at a time
module cspi_master_top import cspi_pkg::*; (
	input  logic              clk_sys,
	input  logic              rst_n,
	input  logic              cmd_valid,
	input  cmd_op_e           cmd_op,
	input  logic [ADDR_W-1:0] cmd_addr,
	input  logic [DATA_W-1:0] cmd_wdata,
	output logic              cmd_ready,
	output logic              rsp_valid,
	output logic [DATA_W-1:0] rsp_data,
	input  logic              rsp_ready,
	output logic              cspi_csn,
	output logic              cspi_sck,
	output logic              cspi_mosi,
	input  logic              cspi_miso
);

	// fifo to controller
	logic              pop_valid;
	logic              pop_ready;
	cmd_op_e           pop_op;
	logic [ADDR_W-1:0] pop_addr;
	logic [DATA_W-1:0] pop_data;

	// controller to phy
	logic              fire;
	logic              done;
	logic [DATA_W-1:0] tx_data;
	logic [DATA_W-1:0] rx_data;

	cspi_cmd_fifo u_fifo (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.push_valid (cmd_valid),
		.push_op    (cmd_op),
		.push_addr  (cmd_addr),
		.push_data  (cmd_wdata),
		.push_ready (cmd_ready),
		.pop_valid  (pop_valid),
		.pop_op     (pop_op),
		.pop_addr   (pop_addr),
		.pop_data   (pop_data),
		.pop_ready  (pop_ready)
	);

	cspi_xfer_ctrl u_ctrl (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.pop_valid (pop_valid),
		.pop_op    (pop_op),
		.pop_addr  (pop_addr),
		.pop_data  (pop_data),
		.pop_ready (pop_ready),
		.fire      (fire),
		.tx_data   (tx_data),
		.done      (done),
		.rx_data   (rx_data),
		.rsp_valid (rsp_valid),
		.rsp_data  (rsp_data),
		.rsp_ready (rsp_ready)
	);

	cspi_byte_phy u_phy (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.fire      (fire),
		.tx_data   (tx_data),
		.done      (done),
		.rx_data   (rx_data),
		.cspi_csn  (cspi_csn),
		.cspi_sck  (cspi_sck),
		.cspi_mosi (cspi_mosi),
		.cspi_miso (cspi_miso)
	);

endmodule

//--- verif/cspi_slave_model.sv
// behavioural 128-byte register device; expects sck idling high and exactly two frames per command
module cspi_slave_model import cspi_pkg::*; (
	input  logic rst_n,
	input  logic cspi_csn,
	input  logic cspi_sck,
	input  logic cspi_mosi,
	output logic cspi_miso
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int MEM_WORDS = 2 ** ADDR_W;

	logic [DATA_W-1:0] mem [MEM_WORDS];
	logic [DATA_W-1:0] rx_sr;
	logic [DATA_W-1:0] tx_sr;
	logic              data_frame;
	cmd_op_e           op_q;
	logic [ADDR_W-1:0] addr_q;

	// ------------------------------------------------------------------------
	// frame decode
	// ------------------------------------------------------------------------
	// sck only rises inside a frame, so csn high here means a frame just ended
	always @(posedge cspi_sck or posedge cspi_csn or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < MEM_WORDS; i++)
				mem[i] <= {1'b0, ~ADDR_W'(i)};
			rx_sr      <= '0;
			tx_sr      <= '0;
			data_frame <= 1'b0;
			op_q       <= OP_WRITE;
			addr_q     <= '0;
		end else if (!cspi_csn) begin
			// rising bus clock, sample mosi and move to the next outgoing bit
			rx_sr <= {rx_sr[DATA_W-2:0], cspi_mosi};
			tx_sr <= {tx_sr[DATA_W-2:0], 1'b0};
		end else if (!data_frame) begin
			// header done, prepare the data frame reply
			op_q       <= cmd_op_e'(rx_sr[DATA_W-1]);
			addr_q     <= rx_sr[ADDR_W-1:0];
			tx_sr      <= rx_sr[DATA_W-1] ? mem[rx_sr[ADDR_W-1:0]] : '0;
			data_frame <= 1'b1;
		end else begin
			if (op_q == OP_WRITE)
				mem[addr_q] <= rx_sr;
			tx_sr      <= '0;
			data_frame <= 1'b0;
		end
	end

	// msb goes out as csn falls, later bits on each falling sck
	always @(negedge cspi_sck or negedge cspi_csn or negedge rst_n) begin
		if (!rst_n)
			cspi_miso <= 1'b0;
		else
			cspi_miso <= tx_sr[DATA_W-1];
	end

endmodule

//--- verif/tb_cspi_master.sv
// directed tests for the SPI master; stops at the first mismatch, watchdog sized for 11 commands
module tb_cspi_master import cspi_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_HALF      = 4;
	localparam int MEM_WORDS     = 2 ** ADDR_W;
	localparam int NUM_CMDS      = 11;
	localparam int CLKS_PER_CMD  = 600;
	localparam int MARGIN_CLKS   = 2000;
	localparam int HOLD_CLKS     = 300;

	logic              clk_sys   = 1'b0;
	logic              rst_n     = 1'b0;
	logic              cmd_valid = 1'b0;
	cmd_op_e           cmd_op    = OP_WRITE;
	logic [ADDR_W-1:0] cmd_addr  = '0;
	logic [DATA_W-1:0] cmd_wdata = '0;
	logic              rsp_ready = 1'b0;
	logic              cmd_ready;
	logic              rsp_valid;
	logic [DATA_W-1:0] rsp_data;
	logic              cspi_csn;
	logic              cspi_sck;
	logic              cspi_mosi;
	logic              cspi_miso;

	// expected register contents
	logic [DATA_W-1:0] sb [MEM_WORDS];
	logic              written [MEM_WORDS];
	logic [31:0]       lcg_state;
	logic              saw_full;
	logic              watch_sck = 1'b0;

	cspi_master_top u_dut (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.cmd_valid (cmd_valid),
		.cmd_op    (cmd_op),
		.cmd_addr  (cmd_addr),
		.cmd_wdata (cmd_wdata),
		.cmd_ready (cmd_ready),
		.rsp_valid (rsp_valid),
		.rsp_data  (rsp_data),
		.rsp_ready (rsp_ready),
		.cspi_csn  (cspi_csn),
		.cspi_sck  (cspi_sck),
		.cspi_mosi (cspi_mosi),
		.cspi_miso (cspi_miso)
	);

	cspi_slave_model u_dev (
		.rst_n     (rst_n),
		.cspi_csn  (cspi_csn),
		.cspi_sck  (cspi_sck),
		.cspi_mosi (cspi_mosi),
		.cspi_miso (cspi_miso)
	);

	initial begin
		forever #(CLK_HALF) clk_sys = ~clk_sys;
	end

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------
	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [ADDR_W-1:0] rand_addr();
		logic [31:0] r;
		r = next_rand();
		return r[30:24];
	endfunction

	function automatic logic [DATA_W-1:0] rand_byte();
		logic [31:0] r;
		r = next_rand();
		return r[23:16];
	endfunction

	task automatic abort_run();
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_byte(input string name, input logic [DATA_W-1:0] expected,
		input logic [DATA_W-1:0] actual);
		if (actual !== expected) begin
			$display("error at %0t ns: %s expected %02h actual %02h",
				$time, name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("error at %0t ns: %s expected %b actual %b",
				$time, name, expected, actual);
			abort_run();
		end
	endtask

	task automatic record_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		sb[addr]      = data;
		written[addr] = 1'b1;
	endtask

	// holds the fields until the FIFO takes them
	task automatic send_cmd(input cmd_op_e op, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] data);
		@(posedge clk_sys);
		cmd_valid <= 1'b1;
		cmd_op    <= op;
		cmd_addr  <= addr;
		cmd_wdata <= data;
		@(negedge clk_sys);
		while (!cmd_ready) begin
			saw_full = 1'b1;
			@(negedge clk_sys);
		end
		@(posedge clk_sys);
		cmd_valid <= 1'b0;
	endtask

	task automatic wait_rsp_valid();
		@(negedge clk_sys);
		while (!rsp_valid)
			@(negedge clk_sys);
	endtask

	// rsp_ready is high, so the response is taken on the next rising edge
	task automatic take_rsp(output logic [DATA_W-1:0] data);
		wait_rsp_valid();
		data = rsp_data;
		@(posedge clk_sys);
	endtask

	// bus clock must idle high whenever chip select is released
	always @(negedge clk_sys) begin
		if (watch_sck && rst_n && cspi_csn)
			check_bit("cspi_sck", 1'b1, cspi_sck);
	end

	// ------------------------------------------------------------------------
	// tests
	// ------------------------------------------------------------------------
	task automatic reset_state_checks();
		repeat (2) @(negedge clk_sys);
		check_bit("cspi_csn", 1'b1, cspi_csn);
		check_bit("cspi_sck", 1'b1, cspi_sck);
		check_bit("cspi_mosi", 1'b0, cspi_mosi);
		check_bit("cmd_ready", 1'b1, cmd_ready);
		check_bit("rsp_valid", 1'b0, rsp_valid);
		watch_sck = 1'b1;
	endtask

	task automatic write_then_read();
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
		logic [DATA_W-1:0] got;
		addr = rand_addr();
		data = rand_byte();
		send_cmd(OP_WRITE, addr, data);
		record_write(addr, data);
		send_cmd(OP_READ, addr, '0);
		take_rsp(got);
		check_byte("rsp_data", data, got);
	endtask

	task automatic unwritten_read();
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] got;
		addr = rand_addr();
		while (written[addr])
			addr = rand_addr();
		send_cmd(OP_READ, addr, '0);
		take_rsp(got);
		check_byte("rsp_data", {1'b0, ~addr}, got);
	endtask

	task automatic burst_order();
		cmd_op_e           ops [6];
		logic [ADDR_W-1:0] addrs [6];
		logic [DATA_W-1:0] datas [6];
		logic [DATA_W-1:0] expect_q [$];
		logic [ADDR_W-1:0] unread_q [$];
		logic [DATA_W-1:0] got;
		ops = '{OP_WRITE, OP_WRITE, OP_READ, OP_WRITE, OP_READ, OP_READ};
		for (int i = 0; i < 6; i++) begin
			if (ops[i] == OP_WRITE) begin
				addrs[i] = rand_addr();
				datas[i] = rand_byte();
				unread_q.push_back(addrs[i]);
				record_write(addrs[i], datas[i]);
			end else begin
				// oldest write not yet read back, so each read has its own address
				addrs[i] = unread_q.pop_front();
				datas[i] = '0;
				expect_q.push_back(sb[addrs[i]]);
			end
		end
		saw_full = 1'b0;
		fork
			for (int i = 0; i < 6; i++)
				send_cmd(ops[i], addrs[i], datas[i]);
			while (expect_q.size() > 0) begin
				take_rsp(got);
				check_byte("rsp_data", expect_q.pop_front(), got);
			end
		join
		if (!saw_full) begin
			$display("cmd_ready never fell although six commands were queued back to back");
			abort_run();
		end
	endtask

	task automatic rsp_backpressure();
		logic [ADDR_W-1:0] addr_a;
		logic [ADDR_W-1:0] addr_b;
		logic [DATA_W-1:0] first;
		logic [DATA_W-1:0] got;
		addr_a = rand_addr();
		addr_b = rand_addr();
		@(posedge clk_sys);
		rsp_ready <= 1'b0;
		send_cmd(OP_READ, addr_a, '0);
		send_cmd(OP_READ, addr_b, '0);
		wait_rsp_valid();
		first = rsp_data;
		check_byte("rsp_data", sb[addr_a], first);
		repeat (HOLD_CLKS) begin
			@(negedge clk_sys);
			check_bit("rsp_valid", 1'b1, rsp_valid);
			check_byte("rsp_data", first, rsp_data);
		end
		@(posedge clk_sys);
		rsp_ready <= 1'b1;
		// held response accepted on this edge
		@(posedge clk_sys);
		take_rsp(got);
		check_byte("rsp_data", sb[addr_b], got);
	endtask

	// ------------------------------------------------------------------------
	// sequence and watchdog
	// ------------------------------------------------------------------------
	initial begin
		repeat (CLKS_PER_CMD * NUM_CMDS + MARGIN_CLKS) @(posedge clk_sys);
		$display("timeout: the tests did not finish within %0d clocks",
			CLKS_PER_CMD * NUM_CMDS + MARGIN_CLKS);
		abort_run();
	end

	initial begin
		lcg_state = 32'hadbf;
		saw_full  = 1'b0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			sb[i]      = {1'b0, ~ADDR_W'(i)};
			written[i] = 1'b0;
		end
		repeat (5) @(posedge clk_sys);
		rst_n     <= 1'b1;
		rsp_ready <= 1'b1;
		reset_state_checks();
		write_then_read();
		unwritten_read();
		burst_order();
		rsp_backpressure();
		$display("PASS: all tests");
		$finish;
	end

endmodule

//--- files.f
design/cspi_pkg.sv
design/cspi_cmd_fifo.sv
design/cspi_byte_phy.sv
design/cspi_xfer_ctrl.sv
design/cspi_master_top.sv
verif/cspi_slave_model.sv
verif/tb_cspi_master.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_cspi_master -Mdir obj_dir -f files.f \
	&& ./obj_dir/Vtb_cspi_master | tee /dev/stderr | grep -F "PASS: all tests" > /dev/null \
	&& echo "run.sh: simulation passed" \
	|| { echo "run.sh: simulation failed"; exit 1; }
